//--- common/mul_pkg.sv
package mul_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Register width, RV64
  localparam int unsigned XLEN = 64;

  // Reorder buffer tag width and number of tags
  localparam int unsigned ROB_IDX_W = 3;
  localparam int unsigned ROB_DEPTH = 1 << ROB_IDX_W;

  typedef logic [ROB_IDX_W-1:0] rob_idx_t;

  ////////////////////
  // Opcodes
  ////////////////////

  // Multiplier control, one value per M-extension multiply
  typedef enum logic [3:0] {
    MULT_MUL     = 4'd0,
    MULT_MULH    = 4'd1,
    MULT_MULHSU  = 4'd2,
    MULT_MULHU   = 4'd3,
    MULT_MULW    = 4'd4,
    // Anything not decoded as a multiply
    MULT_ILLEGAL = 4'd15
  } mult_ctl_t;

  // Exception causes, mcause encoding
  typedef enum logic [3:0] {
    E_INSTR_ADDR_MISALIGNED = 4'd0,
    E_INSTR_ACCESS_FAULT    = 4'd1,
    E_ILLEGAL_INSTRUCTION   = 4'd2,
    E_BREAKPOINT            = 4'd3,
    E_LD_ADDR_MISALIGNED    = 4'd4,
    E_LD_ACCESS_FAULT       = 4'd5,
    E_ST_ADDR_MISALIGNED    = 4'd6,
    E_ST_ACCESS_FAULT       = 4'd7,
    E_ENV_CALL_UMODE        = 4'd8,
    E_ENV_CALL_SMODE        = 4'd9,
    E_ENV_CALL_MMODE        = 4'd11,
    E_INSTR_PAGE_FAULT      = 4'd12,
    E_LD_PAGE_FAULT         = 4'd13,
    E_ST_PAGE_FAULT         = 4'd15
  } except_code_t;

endpackage

//--- mult/spill_cell_flush.sv
`timescale 1ns/10ps

module spill_cell_flush #(
  parameter type DATA_T = logic
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  flush_i,
  input  logic  valid_i,
  input  logic  ready_i,
  output logic  valid_o,
  output logic  ready_o,
  input  DATA_T data_i,
  output DATA_T data_o
);

  logic  main_valid_q, main_valid_d;
  logic  spill_valid_q, spill_valid_d;
  logic  ready_q;
  DATA_T main_data_q;
  DATA_T spill_data_q;
  logic  accept;
  logic  take;
  logic  load_main;
  logic  load_spill;
  logic  main_from_spill;

  // Input and output handshakes
  assign accept = valid_i & ready_o;
  assign take   = valid_o & ready_i;

  always_comb begin : next_state
    main_valid_d    = main_valid_q;
    spill_valid_d   = spill_valid_q;
    load_main       = 1'b0;
    load_spill      = 1'b0;
    main_from_spill = 1'b0;
    if (take) begin
      // Refill from spill first, else straight from input
      if (spill_valid_q) begin
        main_from_spill = 1'b1;
        spill_valid_d   = 1'b0;
      end else if (accept) begin
        load_main = 1'b1;
      end else begin
        main_valid_d = 1'b0;
      end
    end else if (accept) begin
      // Output stalled, park the new item
      if (main_valid_q) begin
        load_spill    = 1'b1;
        spill_valid_d = 1'b1;
      end else begin
        load_main    = 1'b1;
        main_valid_d = 1'b1;
      end
    end
  end

  // Control state
  // ready low for the first cycle out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      main_valid_q  <= 1'b0;
      spill_valid_q <= 1'b0;
      ready_q       <= 1'b0;
    end else if (flush_i) begin
      main_valid_q  <= 1'b0;
      spill_valid_q <= 1'b0;
      ready_q       <= 1'b1;
    end else begin
      main_valid_q  <= main_valid_d;
      spill_valid_q <= spill_valid_d;
      ready_q       <= ~spill_valid_d;
    end
  end

  // Data registers
  always_ff @(posedge clk_i) begin
    if (main_from_spill) begin
      main_data_q <= spill_data_q;
    end else if (load_main) begin
      main_data_q <= data_i;
    end
    if (load_spill) begin
      spill_data_q <= data_i;
    end
  end

  assign valid_o = main_valid_q;
  assign data_o  = main_data_q;
  assign ready_o = ready_q;

  // Stalled output holds its item
  a_stable_stall : assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o))
    else $error("spill cell: output changed while stalled");

endmodule

//--- mult/mult.sv
`timescale 1ns/10ps

module mult #(
  parameter int unsigned PIPE_DEPTH = 3
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,

  // Handshake
  input  logic                       valid_i,
  input  logic                       ready_i,
  output logic                       valid_o,
  output logic                       ready_o,

  // Operation and result
  input  mul_pkg::mult_ctl_t         ctl_i,
  input  mul_pkg::rob_idx_t          rob_idx_i,
  input  logic [mul_pkg::XLEN-1:0]   rs1_value_i,
  input  logic [mul_pkg::XLEN-1:0]   rs2_value_i,
  output mul_pkg::rob_idx_t          rob_idx_o,
  output logic [mul_pkg::XLEN-1:0]   result_o,
  output logic                       except_raised_o,
  output mul_pkg::except_code_t      except_code_o
);

  import mul_pkg::*;

  localparam int unsigned HALF = XLEN / 2;

  // Packed output of the spill cell
  typedef struct packed {
    logic [XLEN-1:0] res;
    rob_idx_t        rob_idx;
    logic            except_raised;
  } out_data_t;

  // Operands on XLEN+1 bits, sign or zero extended
  logic [XLEN:0]     mult_a;
  logic [XLEN:0]     mult_b;
  logic [2*XLEN-1:0] product;
  logic [XLEN-1:0]   result;
  logic              except_raised;
  logic              pipe_en;

  // Stage 0 is the combinational multiplier output
  logic [XLEN-1:0]   pipe_result [PIPE_DEPTH];
  rob_idx_t          pipe_rob_idx [PIPE_DEPTH];
  logic              pipe_except [PIPE_DEPTH];
  logic              pipe_valid [PIPE_DEPTH];

  out_data_t         out_data_in;
  out_data_t         out_data_out;

  ////////////////////
  // Operands
  ////////////////////

  always_comb begin : operand_sel
    // Unsigned unless the opcode says otherwise
    mult_a = {1'b0, rs1_value_i};
    mult_b = {1'b0, rs2_value_i};
    case (ctl_i)
      MULT_MUL, MULT_MULH: begin
        mult_a = {rs1_value_i[XLEN-1], rs1_value_i};
        mult_b = {rs2_value_i[XLEN-1], rs2_value_i};
      end
      MULT_MULHSU: begin
        mult_a = {rs1_value_i[XLEN-1], rs1_value_i};
      end
      MULT_MULW: begin
        // Low words only, sign extended
        mult_a = {{(HALF+1){rs1_value_i[HALF-1]}}, rs1_value_i[HALF-1:0]};
        mult_b = {{(HALF+1){rs2_value_i[HALF-1]}}, rs2_value_i[HALF-1:0]};
      end
      default: ;
    endcase
  end

  ////////////////////
  // Multiplier
  ////////////////////

  // Signed product of the extended operands, 2*XLEN bits kept
  assign product = $signed({{(XLEN-1){mult_a[XLEN]}}, mult_a})
                 * $signed({{(XLEN-1){mult_b[XLEN]}}, mult_b});

  always_comb begin : result_sel
    result        = '0;
    except_raised = 1'b0;
    case (ctl_i)
      MULT_MUL:                           result = product[XLEN-1:0];
      MULT_MULH, MULT_MULHSU, MULT_MULHU: result = product[2*XLEN-1:XLEN];
      MULT_MULW:                          result = {{HALF{product[HALF-1]}}, product[HALF-1:0]};
      // Illegal word, zero result with the flag
      default:                            except_raised = 1'b1;
    endcase
  end

  ////////////////////
  // Pipeline
  ////////////////////

  // Whole pipe moves when the spill cell can take
  assign pipe_en = ready_o;

  assign pipe_valid[0]   = valid_i;
  assign pipe_result[0]  = result;
  assign pipe_rob_idx[0] = rob_idx_i;
  assign pipe_except[0]  = except_raised;

  for (genvar i = 1; i < PIPE_DEPTH; i++) begin : gen_pipe
    // Valid bits
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        pipe_valid[i] <= 1'b0;
      end else if (flush_i) begin
        pipe_valid[i] <= 1'b0;
      end else if (pipe_en) begin
        pipe_valid[i] <= pipe_valid[i-1];
      end
    end

    // Payload, only loaded with a valid item
    always_ff @(posedge clk_i) begin
      if (pipe_en && pipe_valid[i-1]) begin
        pipe_result[i]  <= pipe_result[i-1];
        pipe_rob_idx[i] <= pipe_rob_idx[i-1];
        pipe_except[i]  <= pipe_except[i-1];
      end
    end
  end

  ////////////////////
  // Output register
  ////////////////////

  assign out_data_in.res           = pipe_result[PIPE_DEPTH-1];
  assign out_data_in.rob_idx       = pipe_rob_idx[PIPE_DEPTH-1];
  assign out_data_in.except_raised = pipe_except[PIPE_DEPTH-1];

  spill_cell_flush #(
    .DATA_T(out_data_t)
  ) u_out_reg (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .flush_i(flush_i),
    .valid_i(pipe_valid[PIPE_DEPTH-1]),
    .ready_i(ready_i),
    .valid_o(valid_o),
    .ready_o(ready_o),
    .data_i (out_data_in),
    .data_o (out_data_out)
  );

  assign result_o        = out_data_out.res;
  assign rob_idx_o       = out_data_out.rob_idx;
  assign except_raised_o = out_data_out.except_raised;

  // Only cause this unit can raise
  assign except_code_o = E_ILLEGAL_INSTRUCTION;

  // Decoder must hand over a defined opcode
  a_ctl_known : assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i |-> ctl_i inside {MULT_MUL, MULT_MULH, MULT_MULHSU, MULT_MULHU,
                              MULT_MULW, MULT_ILLEGAL})
    else $error("mult: unknown ctl value %0d", ctl_i);

endmodule

//--- hw/mul_decoder.sv
`timescale 1ns/10ps

module mul_decoder (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            flush_i,
  input  logic                            valid_i,
  input  logic [31:0]                     instr_i,
  input  logic [mul_pkg::XLEN-1:0]        rs1_value_i,
  input  logic [mul_pkg::XLEN-1:0]        rs2_value_i,
  output logic                            ready_o,
  input  logic [mul_pkg::ROB_DEPTH-1:0]   tag_busy_i,
  input  logic                            exec_ready_i,
  output logic                            exec_valid_o,
  output mul_pkg::mult_ctl_t              ctl_o,
  output mul_pkg::rob_idx_t               rob_idx_o,
  output logic                            issue_o
);

  import mul_pkg::*;

  // Major opcodes and funct7 of the M extension
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_32  = 7'b0111011;
  localparam logic [6:0] F7_MULDIV  = 7'b0000001;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rob_idx_t   next_tag_q;

  // Instruction fields
  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Multiply decode
  // Divide and remainder funct3 fall to illegal
  always_comb begin : decode
    ctl_o = MULT_ILLEGAL;
    if (funct7 == F7_MULDIV) begin
      if (opcode == OPC_OP) begin
        case (funct3)
          3'b000:  ctl_o = MULT_MUL;
          3'b001:  ctl_o = MULT_MULH;
          3'b010:  ctl_o = MULT_MULHSU;
          3'b011:  ctl_o = MULT_MULHU;
          default: ctl_o = MULT_ILLEGAL;
        endcase
      end else if (opcode == OPC_OP_32 && funct3 == 3'b000) begin
        ctl_o = MULT_MULW;
      end
    end
  end

  // Accept only with a free tag and room in the multiplier
  // No accept while flushing, the item would be dropped
  assign ready_o      = exec_ready_i & ~tag_busy_i[next_tag_q] & ~flush_i;
  assign issue_o      = valid_i & ready_o;
  assign exec_valid_o = issue_o;
  assign rob_idx_o    = next_tag_q;

  // Tag counter, wraps over all tags
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      next_tag_q <= '0;
    end else if (flush_i) begin
      next_tag_q <= '0;
    end else if (issue_o) begin
      next_tag_q <= next_tag_q + rob_idx_t'(1);
    end
  end

  // Issued tag free now, marked busy by the tracker next cycle
  a_tag_free_on_issue : assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    issue_o |-> !tag_busy_i[rob_idx_o] ##1 tag_busy_i[$past(rob_idx_o)])
    else $error("decoder: tag %0d issued while busy", rob_idx_o);

  // Operands from the issue side must be known
  a_operands_known : assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_o |-> !$isunknown({rs1_value_i, rs2_value_i}))
    else $error("decoder: unknown operand on issue");

endmodule

//--- hw/mul_tag_tracker.sv
`timescale 1ns/10ps

module mul_tag_tracker (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            flush_i,
  input  logic                            issue_i,
  input  mul_pkg::rob_idx_t               issue_idx_i,
  input  logic                            retire_i,
  input  mul_pkg::rob_idx_t               retire_idx_i,
  output logic [mul_pkg::ROB_DEPTH-1:0]   tag_busy_o
);

  import mul_pkg::*;

  logic [ROB_DEPTH-1:0] busy_q;
  logic [ROB_DEPTH-1:0] set_mask;
  logic [ROB_DEPTH-1:0] clr_mask;

  // One-hot set and clear masks
  always_comb begin : masks
    set_mask = '0;
    clr_mask = '0;
    if (issue_i) begin
      set_mask[issue_idx_i] = 1'b1;
    end
    if (retire_i) begin
      clr_mask[retire_idx_i] = 1'b1;
    end
  end

  ////////////////////
  // Busy bits
  ////////////////////

  // Issue and retire never hit the same tag
  // Issued tag is free, retired tag is busy
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= '0;
    end else if (flush_i) begin
      busy_q <= '0;
    end else begin
      busy_q <= (busy_q & ~clr_mask) | set_mask;
    end
  end

  assign tag_busy_o = busy_q;

  // Result must belong to an outstanding issue
  a_retire_busy : assert property (@(posedge clk_i) disable iff (!rst_ni)
    retire_i |-> busy_q[retire_idx_i])
    else $error("tracker: tag %0d retired while free", retire_idx_i);

endmodule

//--- hw/mul_unit_top.sv
`timescale 1ns/10ps

module mul_unit_top #(
  parameter int unsigned PIPE_DEPTH = 3
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,

  // Issue side
  input  logic                       valid_i,
  input  logic [31:0]                instr_i,
  input  logic [mul_pkg::XLEN-1:0]   rs1_value_i,
  input  logic [mul_pkg::XLEN-1:0]   rs2_value_i,
  output logic                       ready_o,

  // Result side
  input  logic                       ready_i,
  output logic                       valid_o,
  output mul_pkg::rob_idx_t          rob_idx_o,
  output logic [mul_pkg::XLEN-1:0]   result_o,
  output logic                       except_raised_o,
  output mul_pkg::except_code_t      except_code_o
);

  import mul_pkg::*;

  logic                 exec_ready;
  logic                 exec_valid;
  mult_ctl_t            ctl;
  rob_idx_t             issue_idx;
  logic                 issue;
  logic                 retire;
  logic [ROB_DEPTH-1:0] tag_busy;

  // Result taken by the consumer
  assign retire = valid_o & ready_i;

  ////////////////////
  // Decode
  ////////////////////

  mul_decoder u_decoder (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .valid_i     (valid_i),
    .instr_i     (instr_i),
    .rs1_value_i (rs1_value_i),
    .rs2_value_i (rs2_value_i),
    .ready_o     (ready_o),
    .tag_busy_i  (tag_busy),
    .exec_ready_i(exec_ready),
    .exec_valid_o(exec_valid),
    .ctl_o       (ctl),
    .rob_idx_o   (issue_idx),
    .issue_o     (issue)
  );

  ////////////////////
  // Execute
  ////////////////////

  mult #(
    .PIPE_DEPTH(PIPE_DEPTH)
  ) u_mult (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .valid_i        (exec_valid),
    .ready_i        (ready_i),
    .valid_o        (valid_o),
    .ready_o        (exec_ready),
    .ctl_i          (ctl),
    .rob_idx_i      (issue_idx),
    .rs1_value_i    (rs1_value_i),
    .rs2_value_i    (rs2_value_i),
    .rob_idx_o      (rob_idx_o),
    .result_o       (result_o),
    .except_raised_o(except_raised_o),
    .except_code_o  (except_code_o)
  );

  // Outstanding tags
  mul_tag_tracker u_tag_tracker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .issue_i     (issue),
    .issue_idx_i (issue_idx),
    .retire_i    (retire),
    .retire_idx_i(rob_idx_o),
    .tag_busy_o  (tag_busy)
  );

endmodule

//--- sim/mul_ref.svh
`ifndef MUL_REF_SVH
`define MUL_REF_SVH

// Major opcodes and funct7 values used to build test words
localparam logic [6:0] OPC_OP     = 7'b0110011;
localparam logic [6:0] OPC_OP_32  = 7'b0111011;
localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
localparam logic [6:0] F7_MULDIV  = 7'b0000001;

// R-type word with fixed register fields
function automatic logic [31:0] enc_r(input logic [6:0] funct7, input logic [2:0] funct3,
                                      input logic [6:0] opcode);
  return {funct7, 5'd2, 5'd1, funct3, 5'd3, opcode};
endfunction

// 0 MUL, 1 MULH, 2 MULHSU, 3 MULHU, 4 MULW
function automatic logic [31:0] mul_instr(input int unsigned op);
  if (op < 4) begin
    return enc_r(F7_MULDIV, 3'(op), OPC_OP);
  end
  return enc_r(F7_MULDIV, 3'd0, OPC_OP_32);
endfunction

// Divide, remainder and non-M words
function automatic logic [31:0] illegal_instr(input int unsigned k);
  logic [31:0] word;
  case (k)
    0, 1, 2, 3: word = enc_r(F7_MULDIV, 3'(k + 4), OPC_OP);
    4, 5, 6, 7: word = enc_r(F7_MULDIV, 3'(k), OPC_OP_32);
    8:          word = enc_r(7'b0000000, 3'd0, OPC_OP);
    default:    word = enc_r(F7_MULDIV, 3'd0, OPC_OP_IMM);
  endcase
  return word;
endfunction

// RISC-V result from the unsigned 128-bit product
// Signed high halves by subtracting the sign corrections
function automatic void ref_mul(input logic [31:0] instr, input logic [63:0] a,
                                input logic [63:0] b, output logic [63:0] res,
                                output logic illegal);
  logic [127:0] prod_u;
  logic [63:0]  hi_u;
  logic [63:0]  prod_w;
  logic         is_m;
  prod_u  = {64'd0, a} * {64'd0, b};
  hi_u    = prod_u[127:64];
  prod_w  = {32'd0, a[31:0]} * {32'd0, b[31:0]};
  is_m    = (instr[31:25] == F7_MULDIV);
  res     = '0;
  illegal = 1'b0;
  if (is_m && instr[6:0] == OPC_OP && instr[14:12] == 3'd0) begin
    res = prod_u[63:0];
  end else if (is_m && instr[6:0] == OPC_OP && instr[14:12] == 3'd1) begin
    res = hi_u - (a[63] ? b : 64'd0) - (b[63] ? a : 64'd0);
  end else if (is_m && instr[6:0] == OPC_OP && instr[14:12] == 3'd2) begin
    // rs1 signed, rs2 unsigned
    res = hi_u - (a[63] ? b : 64'd0);
  end else if (is_m && instr[6:0] == OPC_OP && instr[14:12] == 3'd3) begin
    res = hi_u;
  end else if (is_m && instr[6:0] == OPC_OP_32 && instr[14:12] == 3'd0) begin
    res = {{32{prod_w[31]}}, prod_w[31:0]};
  end else begin
    illegal = 1'b1;
  end
endfunction

`endif

//--- sim/tb_mul_unit.sv
`timescale 1ns/10ps

module tb_mul_unit;

  import mul_pkg::*;

  localparam int unsigned PIPE_DEPTH      = 3;
  // Directed, random, back-pressure, illegal, backlog, flush
  localparam int unsigned NUM_TXN         = 30 + 500 + 300 + 10 + 12 + 25;
  localparam int unsigned WATCHDOG_CYCLES = NUM_TXN * (PIPE_DEPTH + 20);
  localparam logic [1:0]  READY_LOW       = 2'd0;
  localparam logic [1:0]  READY_HIGH      = 2'd1;
  localparam logic [1:0]  READY_RANDOM    = 2'd2;

  `include "mul_ref.svh"

  typedef struct packed {
    rob_idx_t    tag;
    logic [63:0] res;
    logic        illegal;
  } expect_t;

  logic         clk_i;
  logic         rst_ni;
  logic         flush_i;
  logic         valid_i;
  logic [31:0]  instr_i;
  logic [63:0]  rs1_value_i;
  logic [63:0]  rs2_value_i;
  logic         ready_o;
  logic         ready_i;
  logic         valid_o;
  rob_idx_t     rob_idx_o;
  logic [63:0]  result_o;
  logic         except_raised_o;
  except_code_t except_code_o;

  expect_t      exp_q[$];
  rob_idx_t     exp_tag;
  int           errors;
  int           tests_failed;
  logic [1:0]   ready_mode = READY_HIGH;
  logic         stall_q;
  logic [63:0]  held_result;
  rob_idx_t     held_tag;
  logic         held_exc;

  // Corner operand pairs, the last one for MULW
  logic [63:0] corner_a [6] = '{64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF, 64'd0,
                                64'h7FFF_FFFF_FFFF_FFFF, 64'h8000_0000_0000_0000,
                                64'h1234_5678_8000_0000};
  logic [63:0] corner_b [6] = '{64'hFFFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF,
                                64'h1234_5678_9ABC_DEF0, 64'h7FFF_FFFF_FFFF_FFFF,
                                64'h8000_0000_0000_0000, 64'h0000_0000_FFFF_FFFF};

  mul_unit_top #(
    .PIPE_DEPTH(PIPE_DEPTH)
  ) mul_unit_top_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .valid_i        (valid_i),
    .instr_i        (instr_i),
    .rs1_value_i    (rs1_value_i),
    .rs2_value_i    (rs2_value_i),
    .ready_o        (ready_o),
    .ready_i        (ready_i),
    .valid_o        (valid_o),
    .rob_idx_o      (rob_idx_o),
    .result_o       (result_o),
    .except_raised_o(except_raised_o),
    .except_code_o  (except_code_o)
  );

  always begin
    #4 clk_i = ~clk_i;
  end

  ////////////////////
  // Scoreboard
  ////////////////////

  task automatic check_output();
    expect_t item;
    if (exp_q.size() == 0) begin
      $display("Result with tag %0d at %0t arrived with nothing outstanding", rob_idx_o, $time);
      errors++;
    end else begin
      item = exp_q.pop_front();
      if (rob_idx_o != item.tag) begin
        $display("mismatch at %0t: tag %0d, expected %0d", $time, rob_idx_o, item.tag);
        errors++;
      end
      if (except_raised_o != item.illegal) begin
        $display("mismatch at %0t: exception flag %0b on tag %0d", $time, except_raised_o,
                 item.tag);
        errors++;
      end
      if (item.illegal && except_code_o != E_ILLEGAL_INSTRUCTION) begin
        $display("mismatch at %0t: exception code %0d", $time, except_code_o);
        errors++;
      end
      if (!item.illegal && result_o != item.res) begin
        $display("mismatch at %0t: result %h, expected %h", $time, result_o, item.res);
        errors++;
      end
    end
  endtask

  task automatic record_issue();
    expect_t     item;
    logic [63:0] res;
    logic        illegal;
    ref_mul(instr_i, rs1_value_i, rs2_value_i, res, illegal);
    item.tag     = exp_tag;
    item.res     = res;
    item.illegal = illegal;
    exp_q.push_back(item);
    exp_tag = exp_tag + rob_idx_t'(1);
  endtask

  // Both handshakes sampled on the rising edge
  always @(posedge clk_i) begin
    if (rst_ni) begin
      // Stalled output must hold from the previous edge
      if (stall_q && (!valid_o || result_o != held_result || rob_idx_o != held_tag ||
                      except_raised_o != held_exc)) begin
        $display("mismatch at %0t: output changed while stalled", $time);
        errors++;
      end
      stall_q     = valid_o && !ready_i && !flush_i;
      held_result = result_o;
      held_tag    = rob_idx_o;
      held_exc    = except_raised_o;
      if (flush_i) begin
        exp_q.delete();
        exp_tag = '0;
      end else begin
        if (valid_o && ready_i) begin
          check_output();
        end
        if (valid_i && ready_o) begin
          record_issue();
        end
      end
    end
  end

  // Sole driver of ready_i, mode changes land on the next falling edge
  initial begin
    ready_i = 1'b0;
    forever begin
      @(negedge clk_i);
      ready_i = (ready_mode == READY_RANDOM) ? ($urandom_range(1, 0) == 1)
                                             : (ready_mode == READY_HIGH);
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic set_ready(input logic [1:0] mode);
    @(posedge clk_i);
    ready_mode = mode;
  endtask

  task automatic pick_legal(output logic [31:0] instr, output logic [63:0] a,
                            output logic [63:0] b);
    instr = mul_instr($urandom_range(4, 0));
    a     = {$urandom(), $urandom()};
    b     = {$urandom(), $urandom()};
  endtask

  // Hold the item until ready_o accepts it
  task automatic send(input logic [31:0] instr, input logic [63:0] a, input logic [63:0] b);
    logic accepted;
    @(negedge clk_i);
    valid_i     = 1'b1;
    instr_i     = instr;
    rs1_value_i = a;
    rs2_value_i = b;
    accepted    = 1'b0;
    while (!accepted) begin
      @(posedge clk_i);
      accepted = ready_o;
    end
  endtask

  // Offer items for a fixed window and count what got in
  task automatic offer_burst(input int n_items, input int n_cycles, output int n_acc);
    logic [31:0] instr;
    logic [63:0] a;
    logic [63:0] b;
    n_acc = 0;
    pick_legal(instr, a, b);
    for (int c = 0; c < n_cycles && n_acc < n_items; c++) begin
      @(negedge clk_i);
      valid_i     = 1'b1;
      instr_i     = instr;
      rs1_value_i = a;
      rs2_value_i = b;
      @(posedge clk_i);
      if (ready_o) begin
        n_acc++;
        pick_legal(instr, a, b);
      end
    end
    @(negedge clk_i);
    valid_i = 1'b0;
  endtask

  task automatic finish_test(input string name, input int err_start);
    @(negedge clk_i);
    valid_i = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    if (errors == err_start) begin
      $display("test %s finished, no errors", name);
    end else begin
      tests_failed++;
      $display("test %s finished with %0d errors", name, errors - err_start);
    end
  endtask

  // Limit on the whole run
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout after %0d cycles, results stopped coming out", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    int unsigned seed_init;
    int          n_acc;
    int          err_start;
    logic [31:0] instr;
    logic [63:0] a;
    logic [63:0] b;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    flush_i      = 1'b0;
    valid_i      = 1'b0;
    instr_i      = '0;
    rs1_value_i  = '0;
    rs2_value_i  = '0;
    exp_tag      = '0;
    errors       = 0;
    tests_failed = 0;
    stall_q      = 1'b0;
    seed_init    = $urandom(32'h4488b2f5);
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Corner operands through every multiply
    err_start = errors;
    foreach (corner_a[i]) begin
      for (int unsigned op = 0; op < 5; op++) begin
        send(mul_instr(op), corner_a[i], corner_b[i]);
      end
    end
    finish_test("directed", err_start);

    err_start = errors;
    repeat (500) begin
      pick_legal(instr, a, b);
      send(instr, a, b);
    end
    finish_test("random", err_start);

    err_start = errors;
    set_ready(READY_RANDOM);
    repeat (300) begin
      pick_legal(instr, a, b);
      send(instr, a, b);
    end
    finish_test("backpressure", err_start);
    set_ready(READY_HIGH);

    err_start = errors;
    for (int unsigned k = 0; k < 10; k++) begin
      pick_legal(instr, a, b);
      send(illegal_instr(k), a, b);
    end
    finish_test("illegal", err_start);

    // Consumer stalled, unit must fill up and stop
    err_start = errors;
    set_ready(READY_LOW);
    offer_burst(12, 24, n_acc);
    @(posedge clk_i);
    if (ready_o) begin
      $display("ready_o still high with the output stalled");
      errors++;
    end
    if (n_acc > 8) begin
      $display("%0d instructions accepted with ready_i low, at most 8 allowed", n_acc);
      errors++;
    end
    set_ready(READY_HIGH);
    repeat (12 - n_acc) begin
      pick_legal(instr, a, b);
      send(instr, a, b);
    end
    finish_test("backlog", err_start);

    // Flush with items in flight, nothing old may come out
    err_start = errors;
    set_ready(READY_LOW);
    offer_burst(5, 8, n_acc);
    if (n_acc == 0) begin
      $display("No instruction was in flight before the flush");
      errors++;
    end
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    set_ready(READY_HIGH);
    repeat (PIPE_DEPTH + 4) @(negedge clk_i);
    repeat (20) begin
      pick_legal(instr, a, b);
      send(instr, a, b);
    end
    finish_test("flush", err_start);

    $display("tests run 6, failed %0d, errors %0d", tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+sim
common/mul_pkg.sv
mult/spill_cell_flush.sv
mult/mult.sv
hw/mul_decoder.sv
hw/mul_tag_tracker.sv
hw/mul_unit_top.sv
sim/tb_mul_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the multiply unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert -j 0 --top-module tb_mul_unit -f flist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_mul_unit)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "All tests passed"; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1
